/* l1_store_subsystem.f */
verilog/l1_store_pkg.sv
verilog/sq_l2_if.sv
verilog/rr_arbiter.sv
verilog/l1_store_queue.sv
verilog/l2_store_port.sv
verilog/l1_store_subsystem.sv
test/l1_store_queue_assert.sv
test/l1_store_subsystem_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it once
set -e

cd "$(dirname "$0")"

verilator --binary --assert -f l1_store_subsystem.f \
  --top-module l1_store_subsystem_tb -o l1_store_sim

status=0
output=$(./obj_dir/l1_store_sim 2>&1) || status=$?
echo "$output"

if [ "$status" -eq 0 ] && grep -qx "PASS: all tests" <<< "$output"; then
  exit 0
fi
exit 1

/* test/l1_store_queue_assert.sv */
`timescale 1ns/1ps

module l1_store_queue_assert(
  input clk,
  input reset,
  input dd_store_en,
  input dd_flush_en,
  input dd_membar_en,
  input dd_iinvalidate_en,
  input dd_dinvalidate_en,
  input l1_store_pkg::local_thread_bitmap_t rollback,
  input l1_store_pkg::local_thread_bitmap_t sq_wake_bitmap,
  input dequeue_ready,
  input dequeue_ack,
  input l1_store_pkg::local_thread_idx_t dequeue_idx,
  input l1_store_pkg::cache_line_index_t dequeue_adr,
  input logic [3:0] dequeue_kind);

  // The data-cache stage sends at most one kind of request per cycle
  one_request: assert property (@(posedge clk) disable iff (reset)
    $onehot0({dd_store_en, dd_flush_en, dd_membar_en, dd_iinvalidate_en, dd_dinvalidate_en}))
    else $error("more than one dd request enable is high");

  wake_vs_rollback: assert property (@(posedge clk) disable iff (reset)
    (sq_wake_bitmap & rollback) == '0)
    else $error("a thread is woken and rolled back in the same cycle");

  // Mask and data may still widen through combining, everything else holds
  dequeue_hold: assert property (@(posedge clk) disable iff (reset)
    dequeue_ready && !dequeue_ack |=> dequeue_ready && $stable(dequeue_idx)
      && $stable(dequeue_adr) && $stable(dequeue_kind))
    else $error("dequeue request changed while waiting for ack");

endmodule

bind l1_store_queue l1_store_queue_assert queue_checks(
  .clk(clk),
  .reset(reset),
  .dd_store_en(dd_store_en),
  .dd_flush_en(dd_flush_en),
  .dd_membar_en(dd_membar_en),
  .dd_iinvalidate_en(dd_iinvalidate_en),
  .dd_dinvalidate_en(dd_dinvalidate_en),
  .rollback(rollback),
  .sq_wake_bitmap(sq_wake_bitmap),
  .dequeue_ready(l2.dequeue_ready),
  .dequeue_ack(l2.dequeue_ack),
  .dequeue_idx(l2.dequeue_idx),
  .dequeue_adr(l2.dequeue_adr),
  .dequeue_kind({l2.dequeue_sync, l2.dequeue_flush, l2.dequeue_iinvalidate,
    l2.dequeue_dinvalidate}));

/* test/l1_store_subsystem_tb.sv */
`timescale 1ns/1ps

module l1_store_subsystem_tb;
  import l1_store_pkg::*;

  typedef logic [127:0] word_t;

  localparam int TEST_CYCLES = 80;
  localparam int TEST_COUNT = 7;
  localparam int TIMEOUT_CYCLES = TEST_COUNT * TEST_CYCLES + 100;
  localparam int REQ_WAIT_CYCLES = 20;

  logic clk;
  logic reset;
  logic dd_store_en;
  logic dd_flush_en;
  logic dd_membar_en;
  logic dd_iinvalidate_en;
  logic dd_dinvalidate_en;
  cache_line_index_t dd_store_adr;
  byte_mask_t dd_store_mask;
  cache_line_data_t dd_store_data;
  logic dd_store_sync;
  local_thread_idx_t dd_store_thread_idx;
  cache_line_index_t dd_store_bypass_adr;
  local_thread_idx_t dd_store_bypass_thread_idx;
  local_thread_bitmap_t sq_store_sync_pending;
  byte_mask_t sq_store_bypass_mask;
  cache_line_data_t sq_store_bypass_data;
  logic sq_store_sync_success;
  logic sq_rollback_en;
  local_thread_bitmap_t sq_wake_bitmap;
  logic l2_req_ready;
  logic l2_req_valid;
  local_thread_idx_t l2_req_idx;
  cache_line_index_t l2_req_adr;
  byte_mask_t l2_req_mask;
  cache_line_data_t l2_req_data;
  logic l2_req_sync;
  logic l2_req_flush;
  logic l2_req_iinvalidate;
  logic l2_req_dinvalidate;
  logic l2_resp_valid;
  local_thread_idx_t l2_resp_idx;
  logic l2_resp_sync_success;

  // Requests seen by the L2 model in arrival order
  local_thread_idx_t req_idx_q[$];
  cache_line_index_t req_adr_q[$];
  byte_mask_t req_mask_q[$];
  cache_line_data_t req_data_q[$];
  logic [3:0] req_flags_q[$];

  integer seed = 32'h2058ff72;
  int error_count = 0;
  int cycle_count = 0;

  l1_store_subsystem uut(.*);

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // L2 model accepts whatever the port offers while ready is high
  always @(posedge clk)
  begin
    if (!reset && l2_req_valid && l2_req_ready)
    begin
      req_idx_q.push_back(l2_req_idx);
      req_adr_q.push_back(l2_req_adr);
      req_mask_q.push_back(l2_req_mask);
      req_data_q.push_back(l2_req_data);
      req_flags_q.push_back({l2_req_sync, l2_req_flush, l2_req_iinvalidate, l2_req_dinvalidate});
    end
  end

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("Timeout after %0d cycles with %0d errors so far", cycle_count, error_count);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  task automatic compare_value(input string name, input word_t expected, input word_t got);
    if (got !== expected)
    begin
      $display("Error %s expected %0h got %0h", name, expected, got);
      error_count++;
    end
  endtask

  function automatic cache_line_data_t byte_bits(input byte_mask_t mask);
    cache_line_data_t bits;
    for (int b = 0; b < CACHE_LINE_BYTES; b++)
      bits[b * 8 +: 8] = {8{mask[b]}};
    return bits;
  endfunction

  task automatic random_payload(output byte_mask_t mask, output cache_line_data_t data);
    logic [31:0] r;
    r = $random(seed);
    mask = r[15:0] | 16'h0001;
    data = {$random(seed), $random(seed), $random(seed), $random(seed)};
  endtask

  // One store cycle followed by the registered rollback for it
  task automatic drive_store(input local_thread_idx_t thread, input cache_line_index_t adr,
    input byte_mask_t mask, input cache_line_data_t data, input logic sync, output logic rb);
    @(negedge clk);
    dd_store_en = 1'b1;
    dd_store_thread_idx = thread;
    dd_store_adr = adr;
    dd_store_mask = mask;
    dd_store_data = data;
    dd_store_sync = sync;
    @(negedge clk);
    dd_store_en = 1'b0;
    dd_store_sync = 1'b0;
    rb = sq_rollback_en;
  endtask

  // Kind bits are flush, I-invalidate, D-invalidate and membar
  task automatic drive_command(input local_thread_idx_t thread, input cache_line_index_t adr,
    input logic [3:0] kind, output logic rb);
    @(negedge clk);
    dd_store_thread_idx = thread;
    dd_store_adr = adr;
    {dd_flush_en, dd_iinvalidate_en, dd_dinvalidate_en, dd_membar_en} = kind;
    @(negedge clk);
    {dd_flush_en, dd_iinvalidate_en, dd_dinvalidate_en, dd_membar_en} = 4'b0000;
    rb = sq_rollback_en;
  endtask

  task automatic lookup_bypass(input local_thread_idx_t thread, input cache_line_index_t adr,
    output byte_mask_t mask, output cache_line_data_t data);
    @(negedge clk);
    dd_store_bypass_thread_idx = thread;
    dd_store_bypass_adr = adr;
    @(negedge clk);
    mask = sq_store_bypass_mask;
    data = sq_store_bypass_data;
  endtask

  // Flags are sync, flush, I-invalidate and D-invalidate
  // Data only counts where the mask is set
  task automatic expect_request(input local_thread_idx_t thread, input cache_line_index_t adr,
    input byte_mask_t mask, input cache_line_data_t data, input logic [3:0] flags);
    int waited;
    cache_line_data_t got_data;
    waited = 0;
    while (req_idx_q.size() == 0 && waited < REQ_WAIT_CYCLES)
    begin
      @(negedge clk);
      waited++;
    end
    if (req_idx_q.size() == 0)
    begin
      $display("No L2 request from thread %0d arrived in %0d cycles", thread, REQ_WAIT_CYCLES);
      error_count++;
    end
    else
    begin
      compare_value("l2_req_idx", word_t'(thread), word_t'(req_idx_q.pop_front()));
      compare_value("l2_req_adr", word_t'(adr), word_t'(req_adr_q.pop_front()));
      compare_value("l2_req_mask", word_t'(mask), word_t'(req_mask_q.pop_front()));
      got_data = req_data_q.pop_front();
      compare_value("l2_req_data", data & byte_bits(mask), got_data & byte_bits(mask));
      compare_value("l2_req_flags", word_t'(flags), word_t'(req_flags_q.pop_front()));
    end
  endtask

  // Pulses one L2 response and checks the wake bitmap once it reaches the queue
  task automatic answer_request(input local_thread_idx_t thread, input logic success,
    input local_thread_bitmap_t exp_wake);
    @(negedge clk);
    l2_resp_valid = 1'b1;
    l2_resp_idx = thread;
    l2_resp_sync_success = success;
    @(negedge clk);
    l2_resp_valid = 1'b0;
    compare_value("sq_wake_bitmap", word_t'(exp_wake), word_t'(sq_wake_bitmap));
  endtask

  task automatic plain_store_roundtrip();
    byte_mask_t mask;
    cache_line_data_t data;
    logic rb;
    random_payload(mask, data);
    drive_store(2'd0, 26'h100, mask, data, 1'b0, rb);
    compare_value("sq_rollback_en", word_t'(1'b0), word_t'(rb));
    expect_request(2'd0, 26'h100, mask, data, 4'b0000);
    answer_request(2'd0, 1'b0, 4'b0000);
    random_payload(mask, data);
    drive_store(2'd0, 26'h200, mask, data, 1'b0, rb);
    compare_value("sq_rollback_en", word_t'(1'b0), word_t'(rb));
    expect_request(2'd0, 26'h200, mask, data, 4'b0000);
    answer_request(2'd0, 1'b0, 4'b0000);
  endtask

  task automatic write_combining();
    byte_mask_t mask0;
    byte_mask_t mask1;
    byte_mask_t mask2;
    cache_line_data_t data0;
    cache_line_data_t data1;
    cache_line_data_t data2;
    cache_line_data_t merged;
    logic rb;
    @(negedge clk);
    l2_req_ready = 1'b0;
    random_payload(mask0, data0);
    drive_store(2'd1, 26'h300, mask0, data0, 1'b0, rb);
    random_payload(mask1, data1);
    random_payload(mask2, data2);
    drive_store(2'd2, 26'h400, mask1, data1, 1'b0, rb);
    compare_value("sq_rollback_en", word_t'(1'b0), word_t'(rb));
    // Thread 1 now sits in the port register and blocks the dequeue
    compare_value("l2_req_valid", word_t'(1'b1), word_t'(l2_req_valid));
    compare_value("l2_req_idx", word_t'(2'd1), word_t'(l2_req_idx));
    drive_store(2'd2, 26'h400, mask2, data2, 1'b0, rb);
    compare_value("sq_rollback_en", word_t'(1'b0), word_t'(rb));
    merged = (data1 & ~byte_bits(mask2)) | (data2 & byte_bits(mask2));
    @(negedge clk);
    l2_req_ready = 1'b1;
    expect_request(2'd1, 26'h300, mask0, data0, 4'b0000);
    expect_request(2'd2, 26'h400, mask1 | mask2, merged, 4'b0000);
    answer_request(2'd1, 1'b0, 4'b0000);
    answer_request(2'd2, 1'b0, 4'b0000);
  endtask

  task automatic full_entry_rollback();
    byte_mask_t mask;
    cache_line_data_t data;
    logic rb;
    random_payload(mask, data);
    drive_store(2'd3, 26'h500, mask, data, 1'b0, rb);
    expect_request(2'd3, 26'h500, mask, data, 4'b0000);
    random_payload(mask, data);
    drive_store(2'd3, 26'h600, mask, data, 1'b0, rb);
    compare_value("sq_rollback_en", word_t'(1'b1), word_t'(rb));
    answer_request(2'd3, 1'b0, 4'b1000);
  endtask

  task automatic store_bypass();
    byte_mask_t mask;
    byte_mask_t got_mask;
    cache_line_data_t data;
    cache_line_data_t got_data;
    logic rb;
    random_payload(mask, data);
    drive_store(2'd0, 26'h700, mask, data, 1'b0, rb);
    expect_request(2'd0, 26'h700, mask, data, 4'b0000);
    lookup_bypass(2'd0, 26'h700, got_mask, got_data);
    compare_value("sq_store_bypass_mask", word_t'(mask), word_t'(got_mask));
    compare_value("sq_store_bypass_data", data & byte_bits(mask), got_data & byte_bits(mask));
    lookup_bypass(2'd0, 26'h701, got_mask, got_data);
    compare_value("sq_store_bypass_mask", word_t'(0), word_t'(got_mask));
    answer_request(2'd0, 1'b0, 4'b0000);
    // A pending flush holds no data for the load path
    drive_command(2'd0, 26'h800, 4'b1000, rb);
    compare_value("sq_rollback_en", word_t'(1'b0), word_t'(rb));
    lookup_bypass(2'd0, 26'h800, got_mask, got_data);
    compare_value("sq_store_bypass_mask", word_t'(0), word_t'(got_mask));
    expect_request(2'd0, 26'h800, 16'h0000, '0, 4'b0100);
    answer_request(2'd0, 1'b0, 4'b0000);
  endtask

  task automatic sync_store(input local_thread_idx_t thread, input cache_line_index_t adr,
    input logic success);
    byte_mask_t mask;
    cache_line_data_t data;
    local_thread_bitmap_t bit_oh;
    logic rb;
    bit_oh = local_thread_bitmap_t'(1) << thread;
    random_payload(mask, data);
    drive_store(thread, adr, mask, data, 1'b1, rb);
    compare_value("sq_rollback_en", word_t'(1'b1), word_t'(rb));
    compare_value("sq_store_sync_pending", word_t'(bit_oh), word_t'(sq_store_sync_pending));
    expect_request(thread, adr, mask, data, 4'b1000);
    answer_request(thread, success, bit_oh);
    // The restarted pass collects the result and frees the entry
    drive_store(thread, adr, mask, data, 1'b1, rb);
    compare_value("sq_rollback_en", word_t'(1'b0), word_t'(rb));
    compare_value("sq_store_sync_success", word_t'(success), word_t'(sq_store_sync_success));
    compare_value("sq_store_sync_pending", word_t'(0), word_t'(sq_store_sync_pending));
  endtask

  task automatic commands_and_membar();
    byte_mask_t mask;
    cache_line_data_t data;
    logic rb;
    drive_command(2'd3, 26'ha10, 4'b1000, rb);
    compare_value("sq_rollback_en", word_t'(1'b0), word_t'(rb));
    expect_request(2'd3, 26'ha10, 16'h0000, '0, 4'b0100);
    answer_request(2'd3, 1'b0, 4'b0000);
    drive_command(2'd2, 26'ha00, 4'b0100, rb);
    compare_value("sq_rollback_en", word_t'(1'b0), word_t'(rb));
    expect_request(2'd2, 26'ha00, 16'h0000, '0, 4'b0010);
    answer_request(2'd2, 1'b0, 4'b0000);
    drive_command(2'd1, 26'ha20, 4'b0010, rb);
    compare_value("sq_rollback_en", word_t'(1'b0), word_t'(rb));
    expect_request(2'd1, 26'ha20, 16'h0000, '0, 4'b0001);
    answer_request(2'd1, 1'b0, 4'b0000);
    random_payload(mask, data);
    drive_store(2'd0, 26'hb00, mask, data, 1'b0, rb);
    expect_request(2'd0, 26'hb00, mask, data, 4'b0000);
    drive_command(2'd0, 26'hb00, 4'b0001, rb);
    compare_value("sq_rollback_en", word_t'(1'b1), word_t'(rb));
    answer_request(2'd0, 1'b0, 4'b0001);
    drive_command(2'd0, 26'hb00, 4'b0001, rb);
    compare_value("sq_rollback_en", word_t'(1'b0), word_t'(rb));
  endtask

  initial
  begin
    reset = 1'b1;
    dd_store_en = 1'b0;
    dd_flush_en = 1'b0;
    dd_membar_en = 1'b0;
    dd_iinvalidate_en = 1'b0;
    dd_dinvalidate_en = 1'b0;
    dd_store_adr = '0;
    dd_store_mask = '0;
    dd_store_data = '0;
    dd_store_sync = 1'b0;
    dd_store_thread_idx = '0;
    dd_store_bypass_adr = '0;
    dd_store_bypass_thread_idx = '0;
    l2_req_ready = 1'b1;
    l2_resp_valid = 1'b0;
    l2_resp_idx = '0;
    l2_resp_sync_success = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    plain_store_roundtrip();
    write_combining();
    full_entry_rollback();
    store_bypass();
    sync_store(2'd1, 26'h900, 1'b1);
    // Same thread again so the stored success bit has to change
    sync_store(2'd1, 26'h910, 1'b0);
    commands_and_membar();
    repeat (3) @(negedge clk);
    compare_value("l2 requests left over", word_t'(0), word_t'(req_idx_q.size()));
    $display("Finished after %0d cycles with %0d errors", cycle_count, error_count);
    if (error_count == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

/* verilog/l1_store_pkg.sv */
package l1_store_pkg;

  // Core and cache geometry
  localparam int THREADS_PER_CORE = 4;
  localparam int CACHE_LINE_BYTES = 16;
  localparam int CACHE_LINE_BITS = CACHE_LINE_BYTES * 8;

  // Width of a line address once the byte offset is stripped
  localparam int ADDR_WIDTH = 26;

  // Thread number within a core
  typedef logic [$clog2(THREADS_PER_CORE)-1:0] local_thread_idx_t;

  // One bit per hardware thread
  typedef logic [THREADS_PER_CORE-1:0] local_thread_bitmap_t;

  // Line address without the offset bits
  typedef logic [ADDR_WIDTH-1:0] cache_line_index_t;

  // A full line of data
  typedef logic [CACHE_LINE_BITS-1:0] cache_line_data_t;

  // Byte enables, one per byte of a line
  typedef logic [CACHE_LINE_BYTES-1:0] byte_mask_t;

endpackage

/* verilog/l1_store_queue.sv */
`timescale 1ns/1ps

module l1_store_queue(
  input clk,
  input reset,
  input dd_store_en,
  input dd_flush_en,
  input dd_membar_en,
  input dd_iinvalidate_en,
  input dd_dinvalidate_en,
  input l1_store_pkg::cache_line_index_t dd_store_adr,
  input l1_store_pkg::byte_mask_t dd_store_mask,
  input l1_store_pkg::cache_line_data_t dd_store_data,
  input dd_store_sync,
  input l1_store_pkg::local_thread_idx_t dd_store_thread_idx,
  input l1_store_pkg::cache_line_index_t dd_store_bypass_adr,
  input l1_store_pkg::local_thread_idx_t dd_store_bypass_thread_idx,
  output l1_store_pkg::local_thread_bitmap_t sq_store_sync_pending,
  output l1_store_pkg::byte_mask_t sq_store_bypass_mask,
  output l1_store_pkg::cache_line_data_t sq_store_bypass_data,
  output logic sq_store_sync_success,
  output logic sq_rollback_en,
  output l1_store_pkg::local_thread_bitmap_t sq_wake_bitmap,
  sq_l2_if.queue l2);

  import l1_store_pkg::*;

  // Flattened view of the entries for the dequeue and bypass muxes
  local_thread_bitmap_t ent_request;
  local_thread_bitmap_t ent_valid;
  local_thread_bitmap_t ent_plain;
  local_thread_bitmap_t ent_sync;
  local_thread_bitmap_t ent_sync_success;
  local_thread_bitmap_t ent_flush;
  local_thread_bitmap_t ent_iinvalidate;
  local_thread_bitmap_t ent_dinvalidate;
  cache_line_index_t ent_adr [THREADS_PER_CORE];
  byte_mask_t ent_mask [THREADS_PER_CORE];
  cache_line_data_t ent_data [THREADS_PER_CORE];

  local_thread_bitmap_t rollback;
  local_thread_bitmap_t grant_oh;
  local_thread_idx_t grant_idx;

  rr_arbiter send_arbiter(
    .clk(clk),
    .reset(reset),
    .request(ent_request),
    .update_lru(l2.dequeue_ready && l2.dequeue_ack),
    .grant_oh(grant_oh),
    .grant_idx(grant_idx));

  for (genvar t = 0; t < THREADS_PER_CORE; t++)
  begin : entry_gen
    logic valid;
    logic sent;
    logic resp_rcvd;
    logic sync;
    logic sync_success;
    logic waiting;
    logic flush;
    logic iinvalidate;
    logic dinvalidate;
    cache_line_index_t adr;
    byte_mask_t mask;
    cache_line_data_t data;
    logic this_thread;
    logic store_req;
    logic cmd_req;
    logic membar_req;
    logic send_now;
    logic resp_now;
    logic plain;
    logic can_combine;
    logic restart_sync;
    logic store_alloc;
    logic store_combine;
    logic cmd_alloc;

    assign this_thread = dd_store_thread_idx == local_thread_idx_t'(t);
    assign store_req = dd_store_en && this_thread;
    assign cmd_req = (dd_flush_en || dd_iinvalidate_en || dd_dinvalidate_en) && this_thread;
    assign membar_req = dd_membar_en && this_thread;
    assign send_now = grant_oh[t] && l2.dequeue_ack;
    assign resp_now = l2.response_valid && l2.response_idx == local_thread_idx_t'(t);
    assign plain = !sync && !flush && !iinvalidate && !dinvalidate;

    // Merging is only safe until the entry has left for L2
    assign can_combine = valid && plain && !sent && !send_now && !dd_store_sync
      && adr == dd_store_adr;

    // Second pass of a sync store, which collects the result
    assign restart_sync = valid && sync && resp_rcvd;

    // An entry being answered this cycle can be taken over straight away
    assign store_alloc = store_req && !restart_sync && !can_combine && (!valid || resp_now);
    assign store_combine = store_req && can_combine;
    assign cmd_alloc = cmd_req && (!valid || resp_now);

    // A first-pass sync store always sleeps until L2 answers
    assign rollback[t] = store_req
      ? (dd_store_sync ? !restart_sync
                       : valid && !can_combine && !resp_now && !restart_sync)
      : (cmd_req || membar_req) && valid && !resp_now;

    assign sq_wake_bitmap[t] = resp_now && waiting;
    assign sq_store_sync_pending[t] = valid && sync;

    assign ent_request[t] = valid && !sent;
    assign ent_valid[t] = valid;
    assign ent_plain[t] = plain;
    assign ent_sync[t] = sync;
    assign ent_sync_success[t] = sync_success;
    assign ent_flush[t] = flush;
    assign ent_iinvalidate[t] = iinvalidate;
    assign ent_dinvalidate[t] = dinvalidate;
    assign ent_adr[t] = adr;
    assign ent_mask[t] = mask;
    assign ent_data[t] = data;

    always_ff @(posedge clk, posedge reset)
    begin
      if (reset)
      begin
        valid <= 1'b0;
        sent <= 1'b0;
        resp_rcvd <= 1'b0;
        sync <= 1'b0;
        sync_success <= 1'b0;
        waiting <= 1'b0;
        flush <= 1'b0;
        iinvalidate <= 1'b0;
        dinvalidate <= 1'b0;
      end
      else
      begin
        if (send_now)
          sent <= 1'b1;

        if (sq_wake_bitmap[t])
          waiting <= 1'b0;
        else if (rollback[t])
          waiting <= 1'b1;

        // A sync entry stays until its thread returns for the result
        if (resp_now)
        begin
          if (sync)
          begin
            resp_rcvd <= 1'b1;
            sync_success <= l2.response_sync_success;
          end
          else
            valid <= 1'b0;
        end

        // A new allocation overrides the response handling above
        if (store_req && restart_sync)
          valid <= 1'b0;
        else if (store_alloc || cmd_alloc)
        begin
          valid <= 1'b1;
          sent <= 1'b0;
          resp_rcvd <= 1'b0;
          sync <= store_alloc && dd_store_sync;
          flush <= cmd_alloc && dd_flush_en;
          iinvalidate <= cmd_alloc && dd_iinvalidate_en;
          dinvalidate <= cmd_alloc && dd_dinvalidate_en;
        end
      end
    end

    always_ff @(posedge clk)
    begin
      if (store_alloc || store_combine)
      begin
        for (int b = 0; b < CACHE_LINE_BYTES; b++)
        begin
          if (dd_store_mask[b])
            data[b * 8 +: 8] <= dd_store_data[b * 8 +: 8];
        end
        mask <= store_combine ? (mask | dd_store_mask) : dd_store_mask;
      end
      else if (cmd_alloc)
        mask <= '0;

      if (store_alloc || cmd_alloc)
        adr <= dd_store_adr;
    end
  end

  // Fields follow the granted entry, so a combine before transfer widens the request
  assign l2.dequeue_ready = |grant_oh;
  assign l2.dequeue_idx = grant_idx;
  assign l2.dequeue_adr = ent_adr[grant_idx];
  assign l2.dequeue_mask = ent_mask[grant_idx];
  assign l2.dequeue_data = ent_data[grant_idx];
  assign l2.dequeue_sync = ent_sync[grant_idx];
  assign l2.dequeue_flush = ent_flush[grant_idx];
  assign l2.dequeue_iinvalidate = ent_iinvalidate[grant_idx];
  assign l2.dequeue_dinvalidate = ent_dinvalidate[grant_idx];

  always_ff @(posedge clk)
  begin
    sq_store_bypass_data <= ent_data[dd_store_bypass_thread_idx];
    if (ent_valid[dd_store_bypass_thread_idx] && ent_plain[dd_store_bypass_thread_idx]
      && ent_adr[dd_store_bypass_thread_idx] == dd_store_bypass_adr)
      sq_store_bypass_mask <= ent_mask[dd_store_bypass_thread_idx];
    else
      sq_store_bypass_mask <= '0;

    sq_store_sync_success <= ent_sync_success[dd_store_thread_idx];
  end

  always_ff @(posedge clk, posedge reset)
  begin
    if (reset)
      sq_rollback_en <= 1'b0;
    else
      sq_rollback_en <= |rollback;
  end

endmodule

/* verilog/l1_store_subsystem.sv */
`timescale 1ns/1ps

module l1_store_subsystem(
  input clk,
  input reset,
  input dd_store_en,
  input dd_flush_en,
  input dd_membar_en,
  input dd_iinvalidate_en,
  input dd_dinvalidate_en,
  input l1_store_pkg::cache_line_index_t dd_store_adr,
  input l1_store_pkg::byte_mask_t dd_store_mask,
  input l1_store_pkg::cache_line_data_t dd_store_data,
  input dd_store_sync,
  input l1_store_pkg::local_thread_idx_t dd_store_thread_idx,
  input l1_store_pkg::cache_line_index_t dd_store_bypass_adr,
  input l1_store_pkg::local_thread_idx_t dd_store_bypass_thread_idx,
  output l1_store_pkg::local_thread_bitmap_t sq_store_sync_pending,
  output l1_store_pkg::byte_mask_t sq_store_bypass_mask,
  output l1_store_pkg::cache_line_data_t sq_store_bypass_data,
  output logic sq_store_sync_success,
  output logic sq_rollback_en,
  output l1_store_pkg::local_thread_bitmap_t sq_wake_bitmap,
  input l2_req_ready,
  output logic l2_req_valid,
  output l1_store_pkg::local_thread_idx_t l2_req_idx,
  output l1_store_pkg::cache_line_index_t l2_req_adr,
  output l1_store_pkg::byte_mask_t l2_req_mask,
  output l1_store_pkg::cache_line_data_t l2_req_data,
  output logic l2_req_sync,
  output logic l2_req_flush,
  output logic l2_req_iinvalidate,
  output logic l2_req_dinvalidate,
  input l2_resp_valid,
  input l1_store_pkg::local_thread_idx_t l2_resp_idx,
  input l2_resp_sync_success);

  sq_l2_if sq_l2();

  // Queue ports match by name except the bus
  l1_store_queue store_queue(
    .l2(sq_l2.queue),
    .*);

  l2_store_port store_port(
    .sq(sq_l2.port),
    .*);

endmodule

/* verilog/l2_store_port.sv */
`timescale 1ns/1ps

module l2_store_port(
  input clk,
  input reset,
  input l2_req_ready,
  output logic l2_req_valid,
  output l1_store_pkg::local_thread_idx_t l2_req_idx,
  output l1_store_pkg::cache_line_index_t l2_req_adr,
  output l1_store_pkg::byte_mask_t l2_req_mask,
  output l1_store_pkg::cache_line_data_t l2_req_data,
  output logic l2_req_sync,
  output logic l2_req_flush,
  output logic l2_req_iinvalidate,
  output logic l2_req_dinvalidate,
  input l2_resp_valid,
  input l1_store_pkg::local_thread_idx_t l2_resp_idx,
  input l2_resp_sync_success,
  sq_l2_if.port sq);

  logic load_req;

  // Room exists when the register is empty or drains this cycle
  assign sq.dequeue_ack = !l2_req_valid || l2_req_ready;
  assign load_req = sq.dequeue_ack && sq.dequeue_ready;

  always_ff @(posedge clk, posedge reset)
  begin
    if (reset)
      l2_req_valid <= 1'b0;
    else if (sq.dequeue_ack)
      l2_req_valid <= sq.dequeue_ready;
  end

  always_ff @(posedge clk)
  begin
    if (load_req)
    begin
      l2_req_idx <= sq.dequeue_idx;
      l2_req_adr <= sq.dequeue_adr;
      l2_req_mask <= sq.dequeue_mask;
      l2_req_data <= sq.dequeue_data;
      l2_req_sync <= sq.dequeue_sync;
      l2_req_flush <= sq.dequeue_flush;
      l2_req_iinvalidate <= sq.dequeue_iinvalidate;
      l2_req_dinvalidate <= sq.dequeue_dinvalidate;
    end
  end

  // Responses reach the queue one cycle after they arrive from L2
  always_ff @(posedge clk, posedge reset)
  begin
    if (reset)
      sq.response_valid <= 1'b0;
    else
      sq.response_valid <= l2_resp_valid;
  end

  always_ff @(posedge clk)
  begin
    sq.response_idx <= l2_resp_idx;
    sq.response_sync_success <= l2_resp_sync_success;
  end

endmodule

/* verilog/rr_arbiter.sv */
`timescale 1ns/1ps

module rr_arbiter(
  input clk,
  input reset,
  input l1_store_pkg::local_thread_bitmap_t request,
  input logic update_lru,
  output l1_store_pkg::local_thread_bitmap_t grant_oh,
  output l1_store_pkg::local_thread_idx_t grant_idx);

  import l1_store_pkg::*;

  local_thread_idx_t last_idx;
  local_thread_bitmap_t held_oh;
  local_thread_bitmap_t pick_oh;

  // Search starts just after the last winner, the lowest offset wins
  always_comb
  begin
    local_thread_idx_t cand;
    pick_oh = '0;
    for (int i = THREADS_PER_CORE; i >= 1; i--)
    begin
      cand = last_idx + local_thread_idx_t'(i);
      if (request[cand])
        pick_oh = local_thread_bitmap_t'(1) << cand;
    end
  end

  // A grant that has not transferred yet stays put, so a later requester
  // earlier in the rotation cannot steal it
  assign grant_oh = |(held_oh & request) ? held_oh : pick_oh;

  always_comb
  begin
    grant_idx = '0;
    for (int i = 0; i < THREADS_PER_CORE; i++)
    begin
      if (grant_oh[i])
        grant_idx = local_thread_idx_t'(i);
    end
  end

  always_ff @(posedge clk, posedge reset)
  begin
    if (reset)
    begin
      last_idx <= '0;
      held_oh <= '0;
    end
    else if (update_lru)
    begin
      last_idx <= grant_idx;
      held_oh <= '0;
    end
    else
      held_oh <= grant_oh;
  end

endmodule

/* verilog/sq_l2_if.sv */
`timescale 1ns/1ps

interface sq_l2_if;
  import l1_store_pkg::*;

  // Dequeue request, driven by the store queue
  logic dequeue_ready;
  local_thread_idx_t dequeue_idx;
  cache_line_index_t dequeue_adr;
  byte_mask_t dequeue_mask;
  cache_line_data_t dequeue_data;
  logic dequeue_sync;
  logic dequeue_flush;
  logic dequeue_iinvalidate;
  logic dequeue_dinvalidate;

  // Acknowledge and response, driven by the L2 port
  logic dequeue_ack;
  logic response_valid;
  local_thread_idx_t response_idx;
  logic response_sync_success;

  modport queue(
    output dequeue_ready, dequeue_idx, dequeue_adr, dequeue_mask, dequeue_data,
    output dequeue_sync, dequeue_flush, dequeue_iinvalidate, dequeue_dinvalidate,
    input dequeue_ack, response_valid, response_idx, response_sync_success);

  modport port(
    input dequeue_ready, dequeue_idx, dequeue_adr, dequeue_mask, dequeue_data,
    input dequeue_sync, dequeue_flush, dequeue_iinvalidate, dequeue_dinvalidate,
    output dequeue_ack, response_valid, response_idx, response_sync_success);

endinterface
